/* verilog/decode_pkg.sv */
/*
 * Shared types for the instruction decode stage.
 * Holds the opcode encoding, the 32-bit micro-op layout, the architectural
 * register number, the immediate word and the decoded bundle that leaves
 * the stage. Every RTL file refers to these by scoped name.
 */

package decode_pkg;

// ========================================
// Opcodes
// ========================================

// Representative subset of the major opcodes
// Values not listed here decode as having no operands beyond Rs1 and Rd
typedef enum logic [6:0] {
	OP_NOP    = 7'd0,
	OP_ADD    = 7'd4,
	OP_ADDI   = 7'd5,
	OP_ANDI   = 7'd8,
	OP_CMPI   = 7'd11,
	OP_SHIFT  = 7'd16,
	OP_FLTD   = 7'd18,
	OP_CSR    = 7'd22,
	OP_BCC64  = 7'd35,
	OP_BCCU64 = 7'd39,
	OP_LOAD   = 7'd70,
	OP_STORE  = 7'd84,
	OP_STI    = 7'd86,
	OP_AMO    = 7'd96
} opcode_t;

// ========================================
// Micro-op layout
// ========================================

// One 32-bit micro-op as it arrives from the fetch side
// The opcode sits in the low seven bits and the register fields above it
typedef struct packed {
	// Function code which also carries the upper immediate bits
	logic [6:0] func;
	// Second source register field
	logic [5:0] rs2;
	// First source register field
	logic [5:0] rs1;
	// Destination register field
	logic [5:0] rd;
	// Major opcode
	opcode_t    opcode;
} micro_op_t;

// ========================================
// Decoded values
// ========================================

// Architectural register number
// Bits 5:0 select the register and bit 6 selects the float bank
// A value whose low six bits are all ones names the zero register
typedef logic [7:0] aregno_t;

// Fully extended immediate operand
typedef logic [31:0] imm_t;

// Decoded bundle handed to the rename stage
typedef struct packed {
	// Opcode passed through for the execution units
	opcode_t opcode;
	// Architectural register numbers
	aregno_t rs1;
	aregno_t rs2;
	aregno_t rd;
	// Operand presence flags
	logic    has_rs1;
	logic    has_rs2;
	logic    has_rd;
	// Source names the hard-wired zero register
	logic    rs1z;
	logic    rs2z;
	// An immediate operand is present
	logic    has_imm;
	// Immediate value which is zero when has_imm is low
	imm_t    imm;
} decode_out_t;

endpackage

/* verilog/pipe_reg.sv */
/*
 * Valid-qualified pipeline register.
 * The payload type is set by the type parameter T so the same register
 * serves the raw micro-op and the decoded bundle. The valid flag follows
 * its input every cycle while the payload loads only on a valid input.
 */

`timescale 1ns/10ps

module pipe_reg #(
	parameter type T = logic
) (
	input  logic clk,
	input  logic rst,
	input  logic valid_in,
	input  T     data_in,
	output logic valid_out,
	output T     data_out
);

// Valid flag is control state and clears on reset
always_ff @(posedge clk)
begin
	if (rst)
		valid_out <= 1'b0;
	else
		valid_out <= valid_in;
end

// Payload holds its last value between valid inputs
always_ff @(posedge clk)
begin
	if (valid_in)
		data_out <= data_in;
end

endmodule

/* verilog/decode_imm.sv */
/*
 * Immediate decoder for the decode stage.
 * Detects the immediate forms and builds the 32-bit immediate value.
 * The has_immb output tells the Rs2 decoder that the immediate takes the
 * Rs2 slot, so that no second source register is read. Combinational only.
 */

`timescale 1ns/10ps

module decode_imm (
	input  decode_pkg::micro_op_t op,
	output logic                  has_imm,
	output logic                  has_immb,
	output decode_pkg::imm_t      imm
);

// The func and rs2 fields together form a 13-bit immediate
logic [12:0] imm13;
decode_pkg::imm_t imm13_sx;
decode_pkg::imm_t imm6_zx;

assign imm13 = {op.func, op.rs2};
// Sign extended copy for ALU immediates and store-immediate data
assign imm13_sx = {{19{imm13[12]}}, imm13};
// Shift amounts are never negative so the rs2 field is zero extended
assign imm6_zx = {26'd0, op.rs2};

always_comb
begin
	has_imm = 1'b0;
	has_immb = 1'b0;
	imm = '0;
	case (op.opcode)
	decode_pkg::OP_ADDI, decode_pkg::OP_ANDI, decode_pkg::OP_CMPI:
	begin
		has_imm = 1'b1;
		imm = imm13_sx;
	end
	decode_pkg::OP_SHIFT:
		// Func bit 6 selects shift by immediate amount
		if (op.func[6])
		begin
			has_imm = 1'b1;
			has_immb = 1'b1;
			imm = imm6_zx;
		end
	decode_pkg::OP_STI:
	begin
		// Store data comes from the immediate in place of Rs2
		has_imm = 1'b1;
		has_immb = 1'b1;
		imm = imm13_sx;
	end
	default:
		imm = '0;
	endcase
end

endmodule

/* verilog/decode_rs1.sv */
/*
 * First source register decoder.
 * Maps the rs1 field of a micro-op to an architectural register number
 * and flags whether the operand is used and whether it is the zero
 * register. Combinational only.
 */

`timescale 1ns/10ps

module decode_rs1 (
	input  decode_pkg::micro_op_t op,
	output decode_pkg::aregno_t   rs1,
	output logic                  rs1z,
	output logic                  has_rs1
);

always_comb
begin
	case (op.opcode)
	decode_pkg::OP_FLTD:
	begin
		// Float bank sits at 64 to 127
		rs1 = {2'b01, op.rs1};
		has_rs1 = 1'b1;
	end
	decode_pkg::OP_NOP:
	begin
		// A no-op reads nothing
		rs1 = '0;
		has_rs1 = 1'b0;
	end
	default:
	begin
		// Every other opcode reads Rs1 from the integer bank
		rs1 = {2'b00, op.rs1};
		has_rs1 = 1'b1;
	end
	endcase
end

// All ones in the low six bits names the zero register in either bank
assign rs1z = &rs1[5:0];

endmodule

/* verilog/decode_rs2.sv */
/*
 * Second source register decoder.
 * Maps the rs2 field of a micro-op to an architectural register number.
 * When the immediate decoder reports that the immediate occupies the Rs2
 * slot, the register is dropped. The register number is forced to zero
 * whenever no Rs2 operand exists. Combinational only.
 */

`timescale 1ns/10ps

module decode_rs2 (
	input  decode_pkg::micro_op_t op,
	input  logic                  has_immb,
	output decode_pkg::aregno_t   rs2,
	output logic                  rs2z,
	output logic                  has_rs2
);

// Integer and float forms of the field
decode_pkg::aregno_t rs2_int;
decode_pkg::aregno_t rs2_flt;

assign rs2_int = {2'b00, op.rs2};
assign rs2_flt = {2'b01, op.rs2};

// ========================================
// Operand selection
// ========================================

always_comb
begin
	rs2 = '0;
	has_rs2 = 1'b0;
	// The immediate wins over any register in the Rs2 slot
	if (!has_immb)
	begin
		case (op.opcode)
		decode_pkg::OP_FLTD:
		begin
			rs2 = rs2_flt;
			has_rs2 = 1'b1;
		end
		decode_pkg::OP_CSR:
			// Only the register form of CSR access reads Rs2
			if (op.func[6:4] == 3'd0)
			begin
				rs2 = rs2_int;
				has_rs2 = 1'b1;
			end
		decode_pkg::OP_ADD, decode_pkg::OP_SHIFT,
		decode_pkg::OP_BCC64, decode_pkg::OP_BCCU64,
		decode_pkg::OP_LOAD, decode_pkg::OP_STORE, decode_pkg::OP_AMO:
		begin
			rs2 = rs2_int;
			has_rs2 = 1'b1;
		end
		// Immediate ALU forms use the field as immediate bits and read no Rs2
		// All remaining opcodes read no Rs2 either
		default:
			has_rs2 = 1'b0;
		endcase
	end
end

// Zero register test on the low six bits
// Since rs2 is zero without an operand this flag is never set then
assign rs2z = &rs2[5:0];

endmodule

/* verilog/decode_rd.sv */
/*
 * Destination register decoder.
 * Maps the rd field of a micro-op to an architectural destination
 * register and flags whether the micro-op writes a register at all.
 * Branches, stores and no-ops have no destination. Combinational only.
 */

`timescale 1ns/10ps

module decode_rd (
	input  decode_pkg::micro_op_t op,
	output decode_pkg::aregno_t   rd,
	output logic                  has_rd
);

always_comb
begin
	case (op.opcode)
	decode_pkg::OP_FLTD:
	begin
		// Float results land in the upper bank
		rd = {2'b01, op.rd};
		has_rd = 1'b1;
	end
	decode_pkg::OP_BCC64, decode_pkg::OP_BCCU64,
	decode_pkg::OP_STORE, decode_pkg::OP_STI,
	decode_pkg::OP_NOP:
	begin
		// Nothing is written back for these
		rd = '0;
		has_rd = 1'b0;
	end
	default:
	begin
		// Integer result including loads and atomics
		rd = {2'b00, op.rd};
		has_rd = 1'b1;
	end
	endcase
end

endmodule

/* verilog/decode_stage.sv */
/*
 * Top level of the instruction decode stage.
 * A micro-op is registered on in_valid, decoded by four parallel
 * combinational decoders and the resulting bundle registered again.
 * out_valid and out_dec follow in_valid by exactly two clocks and a new
 * micro-op may enter every cycle. There is no back-pressure.
 */

`timescale 1ns/10ps

module decode_stage (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    in_valid,
	input  decode_pkg::micro_op_t   in_op,
	output logic                    out_valid,
	output decode_pkg::decode_out_t out_dec
);

// Registered micro-op
decode_pkg::micro_op_t op_q;
logic op_valid;

// Decoder results
logic has_imm;
logic has_immb;
decode_pkg::imm_t imm;
decode_pkg::aregno_t rs1;
decode_pkg::aregno_t rs2;
decode_pkg::aregno_t rd;
logic has_rs1;
logic has_rs2;
logic has_rd;
logic rs1z;
logic rs2z;

// Bundle before the output register
decode_pkg::decode_out_t dec_d;

// ========================================
// Input register and decoders
// ========================================

pipe_reg #(.T(decode_pkg::micro_op_t)) i_in_reg (
	.clk       (clk),
	.rst       (rst),
	.valid_in  (in_valid),
	.data_in   (in_op),
	.valid_out (op_valid),
	.data_out  (op_q)
);

decode_imm i_decode_imm (
	.op       (op_q),
	.has_imm  (has_imm),
	.has_immb (has_immb),
	.imm      (imm)
);

decode_rs1 i_decode_rs1 (
	.op      (op_q),
	.rs1     (rs1),
	.rs1z    (rs1z),
	.has_rs1 (has_rs1)
);

// Rs2 yields to an immediate that occupies its slot
decode_rs2 i_decode_rs2 (
	.op       (op_q),
	.has_immb (has_immb),
	.rs2      (rs2),
	.rs2z     (rs2z),
	.has_rs2  (has_rs2)
);

decode_rd i_decode_rd (
	.op     (op_q),
	.rd     (rd),
	.has_rd (has_rd)
);

// ========================================
// Bundle and output register
// ========================================

always_comb
begin
	dec_d.opcode = op_q.opcode;
	dec_d.rs1 = rs1;
	dec_d.rs2 = rs2;
	dec_d.rd = rd;
	dec_d.has_rs1 = has_rs1;
	dec_d.has_rs2 = has_rs2;
	dec_d.has_rd = has_rd;
	dec_d.rs1z = rs1z;
	dec_d.rs2z = rs2z;
	dec_d.has_imm = has_imm;
	dec_d.imm = imm;
end

pipe_reg #(.T(decode_pkg::decode_out_t)) i_out_reg (
	.clk       (clk),
	.rst       (rst),
	.valid_in  (op_valid),
	.data_in   (dec_d),
	.valid_out (out_valid),
	.data_out  (out_dec)
);

endmodule

/* bench/decode_stage_sva.sv */
/*
 * Concurrent assertions for the decode stage, bound into decode_stage.
 * Checks reset of the output valid, the fixed two-cycle latency and the
 * consistency of the Rs2 fields in the output bundle.
 */

`timescale 1ns/10ps

module decode_stage_sva (
	input logic                    clk,
	input logic                    rst,
	input logic                    in_valid,
	input logic                    out_valid,
	input decode_pkg::decode_out_t out_dec
);

// Output valid clears on the cycle after a reset edge
a_reset_valid: assert property (@(posedge clk) rst |=> !out_valid)
	else $error("out_valid high after reset");

// Every accepted micro-op comes out exactly two clocks later
a_latency: assert property (@(posedge clk) disable iff (rst)
	out_valid == $past(in_valid, 2))
	else $error("out_valid does not follow in_valid by two cycles");

// No Rs2 operand means register number zero
a_rs2_absent: assert property (@(posedge clk) disable iff (rst)
	(out_valid && !out_dec.has_rs2) |-> out_dec.rs2 == '0)
	else $error("rs2 nonzero without an Rs2 operand");

a_rs2_zero: assert property (@(posedge clk) disable iff (rst)
	out_valid |-> out_dec.rs2z == (&out_dec.rs2[5:0]))
	else $error("rs2z disagrees with rs2");

endmodule

bind decode_stage decode_stage_sva i_decode_stage_sva (
	.clk       (clk),
	.rst       (rst),
	.in_valid  (in_valid),
	.out_valid (out_valid),
	.out_dec   (out_dec)
);

/* bench/tb_decode_stage.sv */
/*
 * Testbench for the instruction decode stage.
 * Runs a directed set of micro-ops covering both register banks, immediate
 * forms, CSR, no-destination opcodes and the zero register, then 400
 * random micro-ops from an LCG. A reference decode builds the expected
 * bundle, which a monitor compares against each out_valid two clocks later.
 */

`timescale 1ns/10ps

module tb_decode_stage;

localparam int N_DIRECTED = 18;
localparam int N_RANDOM = 400;

logic clk;
logic rst;
logic in_valid;
decode_pkg::micro_op_t in_op;
logic out_valid;
decode_pkg::decode_out_t out_dec;

// Expected bundles and the cycle each micro-op was presented
decode_pkg::decode_out_t exp_q[$];
int issue_q[$];
int cyc = 0;

logic [31:0] lcg_state = 32'd64;

// Opcodes that random stimulus draws from
decode_pkg::opcode_t op_table [14] = '{
	decode_pkg::OP_NOP, decode_pkg::OP_ADD, decode_pkg::OP_ADDI,
	decode_pkg::OP_ANDI, decode_pkg::OP_CMPI, decode_pkg::OP_SHIFT,
	decode_pkg::OP_FLTD, decode_pkg::OP_CSR, decode_pkg::OP_BCC64,
	decode_pkg::OP_BCCU64, decode_pkg::OP_LOAD, decode_pkg::OP_STORE,
	decode_pkg::OP_STI, decode_pkg::OP_AMO
};

decode_stage i_decode_stage (
	.clk       (clk),
	.rst       (rst),
	.in_valid  (in_valid),
	.in_op     (in_op),
	.out_valid (out_valid),
	.out_dec   (out_dec)
);

// ========================================
// Reference model and helpers
// ========================================

function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
	return lcg_state;
endfunction

function automatic decode_pkg::micro_op_t make_op(decode_pkg::opcode_t opc,
	logic [6:0] func, logic [5:0] rs2, logic [5:0] rs1, logic [5:0] rd);
	decode_pkg::micro_op_t op;
	op.func = func;
	op.rs2 = rs2;
	op.rs1 = rs1;
	op.rd = rd;
	op.opcode = opc;
	return op;
endfunction

// Expected bundle built straight from the decode rules
function automatic decode_pkg::decode_out_t ref_decode(decode_pkg::micro_op_t op);
	decode_pkg::decode_out_t d;
	logic [12:0] imm13;
	logic slot_imm;
	d = '0;
	d.opcode = op.opcode;
	imm13 = {op.func, op.rs2};
	slot_imm = 1'b0;
	// Immediate value, negative when bit 12 of the 13-bit field is set
	case (op.opcode)
	decode_pkg::OP_ADDI, decode_pkg::OP_ANDI, decode_pkg::OP_CMPI:
	begin
		d.has_imm = 1'b1;
		d.imm = decode_pkg::imm_t'(int'(imm13) - (imm13[12] ? 8192 : 0));
	end
	decode_pkg::OP_SHIFT:
		if (op.func[6])
		begin
			d.has_imm = 1'b1;
			slot_imm = 1'b1;
			d.imm = decode_pkg::imm_t'(op.rs2);
		end
	decode_pkg::OP_STI:
	begin
		d.has_imm = 1'b1;
		slot_imm = 1'b1;
		d.imm = decode_pkg::imm_t'(int'(imm13) - (imm13[12] ? 8192 : 0));
	end
	default:
		d.has_imm = 1'b0;
	endcase
	// First source
	if (op.opcode == decode_pkg::OP_FLTD)
		d.rs1 = op.rs1 + 8'd64;
	else if (op.opcode != decode_pkg::OP_NOP)
		d.rs1 = op.rs1;
	d.has_rs1 = (op.opcode != decode_pkg::OP_NOP);
	// Second source, absent whenever the immediate fills its slot
	if (!slot_imm)
	begin
		case (op.opcode)
		decode_pkg::OP_FLTD:
			d.rs2 = op.rs2 + 8'd64;
		decode_pkg::OP_CSR:
			if (op.func[6:4] == 3'b000)
				d.rs2 = op.rs2;
		decode_pkg::OP_ADD, decode_pkg::OP_SHIFT, decode_pkg::OP_BCC64,
		decode_pkg::OP_BCCU64, decode_pkg::OP_LOAD, decode_pkg::OP_STORE,
		decode_pkg::OP_AMO:
			d.rs2 = op.rs2;
		default:
			d.rs2 = 8'd0;
		endcase
		d.has_rs2 = (op.opcode == decode_pkg::OP_FLTD) ||
			(op.opcode == decode_pkg::OP_CSR && op.func[6:4] == 3'b000) ||
			(op.opcode inside {decode_pkg::OP_ADD, decode_pkg::OP_SHIFT,
			decode_pkg::OP_BCC64, decode_pkg::OP_BCCU64, decode_pkg::OP_LOAD,
			decode_pkg::OP_STORE, decode_pkg::OP_AMO});
	end
	// Destination
	d.has_rd = !(op.opcode inside {decode_pkg::OP_BCC64, decode_pkg::OP_BCCU64,
		decode_pkg::OP_STORE, decode_pkg::OP_STI, decode_pkg::OP_NOP});
	if (d.has_rd)
		d.rd = (op.opcode == decode_pkg::OP_FLTD) ? op.rd + 8'd64 : op.rd;
	// Register 63 and register 127 are the zero register
	d.rs1z = (d.rs1 % 64) == 63;
	d.rs2z = (d.rs2 % 64) == 63;
	return d;
endfunction

task automatic fail_run();
	$display("FAIL: see errors above");
	$fatal(1, "Stopping at first error");
endtask

// ========================================
// Compare tasks
// ========================================

task automatic check_areg(string name, decode_pkg::aregno_t got, decode_pkg::aregno_t want);
	if (got !== want)
	begin
		$display("ERR %0t %s got %0d expected %0d", $time, name, got, want);
		fail_run();
	end
endtask

task automatic check_flag(string name, logic got, logic want);
	if (got !== want)
	begin
		$display("ERR %0t %s got %b expected %b", $time, name, got, want);
		fail_run();
	end
endtask

task automatic check_imm(string name, decode_pkg::imm_t got, decode_pkg::imm_t want);
	if (got !== want)
	begin
		$display("ERR %0t %s got %h expected %h", $time, name, got, want);
		fail_run();
	end
endtask

task automatic check_opcode(string name, decode_pkg::opcode_t got, decode_pkg::opcode_t want);
	if (got !== want)
	begin
		$display("ERR %0t %s got %h expected %h", $time, name, got, want);
		fail_run();
	end
endtask

// ========================================
// Clock, drivers and monitor
// ========================================

initial
begin
	clk = 1'b0;
	forever #5 clk = ~clk;
end

always @(posedge clk)
	cyc <= cyc + 1;

// Present one micro-op and record what should come out
task automatic send_op(decode_pkg::micro_op_t op);
	in_valid = 1'b1;
	in_op = op;
	exp_q.push_back(ref_decode(op));
	issue_q.push_back(cyc);
	@(posedge clk);
	#1;
endtask

task automatic send_idle(int n);
	in_valid = 1'b0;
	repeat (n)
	begin
		@(posedge clk);
		#1;
	end
endtask

// Outputs are sampled on the falling edge, well clear of the register updates
initial
begin
	decode_pkg::decode_out_t want;
	int issued;
	forever
	begin
		@(negedge clk);
		if (!rst && out_valid === 1'b1)
		begin
			if (exp_q.size() == 0)
			begin
				$display("Output valid at %0t with no micro-op outstanding", $time);
				fail_run();
			end
			want = exp_q.pop_front();
			issued = issue_q.pop_front();
			if (cyc != issued + 2)
			begin
				$display("Output at cycle %0d for a micro-op sent at cycle %0d", cyc, issued);
				fail_run();
			end
			check_opcode("opcode", out_dec.opcode, want.opcode);
			check_areg("rs1", out_dec.rs1, want.rs1);
			check_areg("rs2", out_dec.rs2, want.rs2);
			check_areg("rd", out_dec.rd, want.rd);
			check_flag("has_rs1", out_dec.has_rs1, want.has_rs1);
			check_flag("has_rs2", out_dec.has_rs2, want.has_rs2);
			check_flag("has_rd", out_dec.has_rd, want.has_rd);
			check_flag("rs1z", out_dec.rs1z, want.rs1z);
			check_flag("rs2z", out_dec.rs2z, want.rs2z);
			check_flag("has_imm", out_dec.has_imm, want.has_imm);
			check_imm("imm", out_dec.imm, want.imm);
		end
	end
end

// Budget of two cycles per micro-op with some slack
initial
begin
	repeat ((N_DIRECTED + N_RANDOM + 20) * 2) @(posedge clk);
	$display("Timeout at %0t, outputs stopped arriving", $time);
	fail_run();
end

// ========================================
// Stimulus
// ========================================

initial
begin
	decode_pkg::micro_op_t op;
	logic [31:0] r;
	int n;
	rst = 1'b1;
	in_valid = 1'b0;
	in_op = '0;
	repeat (10) @(posedge clk);
	#1;
	rst = 1'b0;

	// Banks, then immediates in and out of the Rs2 slot
	send_op(make_op(decode_pkg::OP_FLTD, 7'h00, 6'd9, 6'd5, 6'd12));
	send_op(make_op(decode_pkg::OP_ADD, 7'h00, 6'd9, 6'd5, 6'd12));
	send_op(make_op(decode_pkg::OP_SHIFT, 7'h40, 6'd13, 6'd3, 6'd4));
	send_op(make_op(decode_pkg::OP_SHIFT, 7'h00, 6'd13, 6'd3, 6'd4));
	send_op(make_op(decode_pkg::OP_STI, 7'h7f, 6'h30, 6'd2, 6'd1));
	send_op(make_op(decode_pkg::OP_ADDI, 7'h7f, 6'h3f, 6'd1, 6'd2));
	send_op(make_op(decode_pkg::OP_ANDI, 7'h12, 6'h05, 6'd1, 6'd2));
	send_op(make_op(decode_pkg::OP_CMPI, 7'h40, 6'h00, 6'd1, 6'd2));
	send_idle(1);
	// CSR forms and opcodes with no destination
	send_op(make_op(decode_pkg::OP_CSR, 7'h0f, 6'd7, 6'd8, 6'd9));
	send_op(make_op(decode_pkg::OP_CSR, 7'h10, 6'd7, 6'd8, 6'd9));
	send_op(make_op(decode_pkg::OP_BCC64, 7'h00, 6'd1, 6'd2, 6'd3));
	send_op(make_op(decode_pkg::OP_BCCU64, 7'h00, 6'd1, 6'd2, 6'd3));
	send_op(make_op(decode_pkg::OP_STORE, 7'h00, 6'd4, 6'd5, 6'd6));
	send_idle(2);
	send_op(make_op(decode_pkg::OP_NOP, 7'h00, 6'd63, 6'd63, 6'd63));
	send_op(make_op(decode_pkg::OP_LOAD, 7'h00, 6'd4, 6'd5, 6'd6));
	send_op(make_op(decode_pkg::OP_AMO, 7'h00, 6'd4, 6'd5, 6'd6));
	// Zero register in both banks
	send_op(make_op(decode_pkg::OP_ADD, 7'h00, 6'd63, 6'd63, 6'd63));
	send_op(make_op(decode_pkg::OP_FLTD, 7'h00, 6'd63, 6'd63, 6'd63));

	// Random micro-ops with about one idle cycle in four
	n = 0;
	while (n < N_RANDOM)
	begin
		r = lcg_next();
		if (r[31:30] == 2'b00)
		begin
			send_idle(1);
		end
		else
		begin
			r = lcg_next();
			op.func = r[31:25];
			op.rs2 = r[24:19];
			op.rs1 = r[18:13];
			op.rd = r[12:7];
			r = lcg_next();
			op.opcode = op_table[r[30:16] % 14];
			send_op(op);
			n++;
		end
	end
	send_idle(1);

	// The last micro-op is due two clocks after it was sent
	// A few more cycles let a stray or missing output show up
	repeat (5) @(posedge clk);
	if (exp_q.size() != 0)
	begin
		$display("Micro-ops still outstanding at end of run");
		fail_run();
	end
	else
	begin
		$display("PASS: all tests");
		$finish;
	end
end

endmodule

/* files.f */
verilog/decode_pkg.sv
verilog/pipe_reg.sv
verilog/decode_imm.sv
verilog/decode_rs1.sv
verilog/decode_rs2.sv
verilog/decode_rd.sv
verilog/decode_stage.sv
bench/decode_stage_sva.sv
bench/tb_decode_stage.sv

/* Bender.yml */
package:
  name: decode_stage

sources:
  - files:
      - verilog/decode_pkg.sv
      - verilog/pipe_reg.sv
      - verilog/decode_imm.sv
      - verilog/decode_rs1.sv
      - verilog/decode_rs2.sv
      - verilog/decode_rd.sv
      - verilog/decode_stage.sv
  - target: test
    files:
      - bench/decode_stage_sva.sv
      - bench/tb_decode_stage.sv
